//--- logic/nocPkg.sv
package nocPkg;

  localparam integer numPorts = 5;
  localparam integer portIdxWidth = 3;
  localparam integer lengthWidth = 12;
  localparam integer dataWidth = 16;

  // index of each port in req, timesUp and the flit array
  localparam logic [portIdxWidth-1:0] portL = portIdxWidth'(0);
  localparam logic [portIdxWidth-1:0] portN = portIdxWidth'(1);
  localparam logic [portIdxWidth-1:0] portE = portIdxWidth'(2);
  localparam logic [portIdxWidth-1:0] portW = portIdxWidth'(3);
  localparam logic [portIdxWidth-1:0] portS = portIdxWidth'(4);

  typedef enum logic [2:0]
  {
    flitNone = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitKind;

  typedef struct packed
  {
    flitKind kind;
    logic [lengthWidth-1:0] length;  // valid on head flits
    logic [dataWidth-1:0] data;
  } flitT;

  // one-hot, bit n+1 belongs to port index n
  typedef enum logic [5:0]
  {
    grantIdle = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } grantT;

  typedef logic [numPorts-1:0] portMaskT;
  typedef flitT [numPorts-1:0] flitArrayT;

  // returns 1 and the port index when the grant names a single port
  function automatic logic grantOwner(input grantT g,
                                      output logic [portIdxWidth-1:0] idx);
    logic isPort;
    isPort = 1'b1;
    idx = portL;
    case (g)
      grantL: idx = portL;
      grantN: idx = portN;
      grantE: idx = portE;
      grantW: idx = portW;
      grantS: idx = portS;
      default: isPort = 1'b0;  // idle or not one-hot
    endcase
    return isPort;
  endfunction

endpackage

//--- logic/leaseTimer.sv
`timescale 1ns/1ns

module leaseTimer
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitKind kind,
  input  logic [nocPkg::lengthWidth-1:0] length,
  input  logic runTimer,
  output logic timesUp
);

  import nocPkg::*;

  logic [lengthWidth-1:0] limit;  // lease length of the current packet
  logic [lengthWidth-1:0] count;  // cycles held so far

  // limit follows every head flit seen on this port,
  // granted or not
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (kind == flitHead)
    begin
      limit <= length;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;  // no lease running
    end
  end

  // a limit of 0 ends the lease after one cycle
  always_comb
  begin
    timesUp = (count == limit);
  end

endmodule

//--- logic/grantFsm.sv
`timescale 1ns/1ns

module grantFsm
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::portMaskT req,
  input  nocPkg::portMaskT timesUp,
  output nocPkg::portMaskT runTimer,
  output nocPkg::grantT grant
);

  import nocPkg::*;

  grantT nextGrant;
  logic owned;                         // grant names a port
  logic [portIdxWidth-1:0] ownerIdx;   // index of that port
  logic holding;                       // owner keeps the output

  // first requester in cyclic order, looking at span ports from first on
  function automatic grantT scanFrom(input portMaskT reqs,
                                     input logic [portIdxWidth-1:0] first,
                                     input integer span);
    integer idx;
    logic found;
    grantT pick;
    found = 1'b0;
    pick = grantIdle;
    for (integer k = 0; k < numPorts; k++)
    begin
      idx = first + k;
      if (idx >= numPorts)
      begin
        idx = idx - numPorts;  // wrap past S back to L
      end
      if (!found && (k < span) && reqs[idx])
      begin
        found = 1'b1;
        pick = grantT'(grantL << idx);
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  always_comb
  begin
    owned = grantOwner(grant, ownerIdx);
    holding = owned && req[ownerIdx] && !timesUp[ownerIdx];
  end

  always_comb
  begin
    runTimer = '0;
    if (grant == grantIdle)
    begin
      nextGrant = scanFrom(req, portL, numPorts);  // fixed order from idle
    end
    else if (!owned)
    begin
      nextGrant = grantIdle;  // recover from a broken encoding
    end
    else if (holding)
    begin
      runTimer[ownerIdx] = 1'b1;
      nextGrant = grant;
    end
    else
    begin
      // the owner itself is left out, so it never wins twice in a row
      nextGrant = scanFrom(req, ownerIdx + 1'b1, numPorts - 1);
    end
  end

endmodule

//--- logic/flitSelect.sv
`timescale 1ns/1ns

module flitSelect
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::grantT grant,
  input  nocPkg::flitArrayT inFlit,
  output nocPkg::flitT outFlit,
  output logic outValid
);

  import nocPkg::*;

  logic granted;
  logic [portIdxWidth-1:0] srcIdx;
  flitT selFlit;
  logic selValid;

  // one output column of the crossbar
  always_comb
  begin
    granted = grantOwner(grant, srcIdx);
    if (granted)
    begin
      selFlit = inFlit[srcIdx];
    end
    else
    begin
      selFlit = '{kind: flitNone, default: '0};
    end
    selValid = granted && (selFlit.kind != flitNone);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit <= selFlit;
      outValid <= selValid;  // empty slot on a granted port stays invalid
    end
  end

endmodule

//--- logic/portArbiter.sv
`timescale 1ns/1ns

module portArbiter
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::portMaskT req,
  input  nocPkg::flitArrayT inFlit,
  output nocPkg::grantT grant,
  output nocPkg::flitT outFlit,
  output logic outValid
);

  import nocPkg::*;

  portMaskT runTimer;  // lease running, one bit per port
  portMaskT timesUp;   // lease used up, one bit per port

  // one lease timer per input port, loaded from that port's head flits
  generate
    for (genvar p = 0; p < numPorts; p++)
    begin : timerBank
      leaseTimer portTimer
      (
        .clk(clk),
        .rst(rst),
        .kind(inFlit[p].kind),
        .length(inFlit[p].length),
        .runTimer(runTimer[p]),
        .timesUp(timesUp[p])
      );
    end
  endgenerate

  grantFsm grantUnit
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .timesUp(timesUp),
    .runTimer(runTimer),
    .grant(grant)
  );

  // request to outFlit is two cycles, one here and one in the FSM
  flitSelect outSlice
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .inFlit(inFlit),
    .outFlit(outFlit),
    .outValid(outValid)
  );

endmodule

//--- verif/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // released between rising edges
  end

endmodule

//--- verif/arbiterChecker.sv
`timescale 1ns/1ns

module arbiterChecker
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::portMaskT req,
  input  nocPkg::flitArrayT inFlit,
  input  nocPkg::grantT grant,
  input  nocPkg::flitT outFlit,
  input  logic outValid,
  output integer checkCount,
  output integer errorCount
);

  import nocPkg::*;

  logic [5:0] mGrant;                     // model grant, bit 0 is idle
  logic [lengthWidth-1:0] mLimit [numPorts];
  logic [lengthWidth-1:0] mCount [numPorts];
  flitT mFlit;
  logic mValid;

  // next grant, and the one lease that keeps running
  function automatic logic [5:0] refNextGrant(input logic [5:0] cur, input portMaskT r,
                                              input portMaskT up, output portMaskT run);
    integer owner;
    integer p;
    logic [5:0] nxt;
    run = '0;
    nxt = 6'b000001;
    owner = -1;
    for (p = 0; p < numPorts; p++)
    begin
      if ($countones(cur) == 1 && cur[p + 1])
        owner = p;
    end
    if (cur == 6'b000001)
    begin
      for (p = numPorts - 1; p >= 0; p--)  // last hit is the lowest index
        if (r[p])
          nxt = 6'b1 << (p + 1);
    end
    else if (owner >= 0 && r[owner] && !up[owner])
    begin
      run[owner] = 1'b1;
      nxt = cur;
    end
    else if (owner >= 0)
    begin
      for (p = numPorts - 1; p >= 1; p--)  // nearest after the owner wins
        if (r[(owner + p) % numPorts])
          nxt = 6'b1 << ((owner + p) % numPorts + 1);
    end
    return nxt;
  endfunction

  task automatic compare(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    checkCount++;
    if (expVal !== actVal)
    begin
      errorCount++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
    end
  endtask

  initial
  begin
    checkCount = 0;
    errorCount = 0;
  end

  // outputs still hold last cycle's values here
  always @(posedge clk)
  begin : modelStep
    portMaskT up;
    portMaskT run;
    logic [5:0] nxt;
    if (rst)
    begin
      mGrant = 6'b000001;
      mFlit = '0;
      mValid = 1'b0;
      for (integer p = 0; p < numPorts; p++)
      begin
        mLimit[p] = '0;
        mCount[p] = '0;
      end
    end
    else
    begin
      compare("grant", mGrant, grant);
      compare("outFlit", mFlit, outFlit);
      compare("outValid", mValid, outValid);
      for (integer p = 0; p < numPorts; p++)
        up[p] = (mCount[p] == mLimit[p]);
      nxt = refNextGrant(mGrant, req, up, run);
      mFlit = '0;
      mValid = 1'b0;
      for (integer p = 0; p < numPorts; p++)
      begin
        if (mGrant[p + 1])
        begin
          mFlit = inFlit[p];
          mValid = (inFlit[p].kind != flitNone);
        end
        if (inFlit[p].kind == flitHead)
          mLimit[p] = inFlit[p].length;
        mCount[p] = run[p] ? mCount[p] + 1'b1 : '0;
      end
      mGrant = nxt;
    end
  end

endmodule

//--- verif/tbPortArbiter.sv
`timescale 1ns/1ns

module tbPortArbiter;

  import nocPkg::*;

  logic clk;
  logic rst;
  portMaskT req;
  flitArrayT inFlit;
  grantT grant;
  flitT outFlit;
  logic outValid;
  integer checkCount;
  integer errorCount;
  integer timeouts;
  logic [31:0] lfsr;

  clockGen clkUnit (.clk(clk), .rst(rst));

  portArbiter uut (.clk(clk), .rst(rst), .req(req), .inFlit(inFlit),
                   .grant(grant), .outFlit(outFlit), .outValid(outValid));

  arbiterChecker monitorUnit (.clk(clk), .rst(rst), .req(req), .inFlit(inFlit),
                              .grant(grant), .outFlit(outFlit), .outValid(outValid),
                              .checkCount(checkCount), .errorCount(errorCount));

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randBits(input integer n, output logic [31:0] v);
    v = '0;
    for (integer i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic setFlit(input integer p, input flitKind k, input integer len);
    inFlit[p].kind = k;
    inFlit[p].length = lengthWidth'(len);
    inFlit[p].data = dataWidth'(p * 256 + len);
  endtask

  task automatic waitForGrant(input logic [5:0] want, input integer limit);
    integer n;
    n = 0;
    while (grant !== want && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (grant !== want)
    begin
      timeouts++;
      $display("timeout: grant did not reach %b within %0d cycles", want, limit);
    end
  endtask

  initial
  begin : stimulus
    logic [31:0] r;
    integer n;
    timeouts = 0;
    lfsr = 32'h7e92_bbae;
    req = '0;
    inFlit = '0;
    n = 0;
    while (rst !== 1'b0 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0)
    begin
      timeouts++;
      $display("timeout: reset was never released");
    end
    repeat (3) @(negedge clk);
    for (integer p = 0; p < numPorts; p++)
      setFlit(p, flitHead, 0);  // one-cycle leases everywhere
    req = 5'b11010;             // idle priority picks N first
    waitForGrant(grantN, 4);
    req = '0;
    waitForGrant(grantIdle, 8);
    req = 5'b10000;  // single request
    waitForGrant(grantS, 4);
    req = '1;        // round robin
    waitForGrant(grantL, 8);
    repeat (12) @(negedge clk);
    req = '0;
    waitForGrant(grantIdle, 4);
    setFlit(2, flitHead, 3);    // lease of 4 cycles on E
    req = 5'b00100;
    @(negedge clk);
    setFlit(2, flitBody, 3);
    waitForGrant(grantE, 4);
    waitForGrant(grantIdle, 8);
    waitForGrant(grantE, 4);
    req = '0;
    waitForGrant(grantIdle, 8);
    setFlit(1, flitHead, 10);   // early release from N to W
    setFlit(3, flitHead, 10);
    req = 5'b01010;
    @(negedge clk);
    setFlit(1, flitBody, 10);
    setFlit(3, flitBody, 10);
    waitForGrant(grantN, 4);
    repeat (2) @(negedge clk);
    req[1] = 1'b0;
    waitForGrant(grantW, 2);
    req = '0;
    waitForGrant(grantIdle, 2);
    for (integer i = 0; i < 400; i++)
    begin
      @(negedge clk);
      randBits(5, r);
      req = r[4:0];
      for (integer p = 0; p < numPorts; p++)
      begin
        randBits(2, r);
        inFlit[p].kind = flitKind'({1'b0, r[1:0]});
        if (inFlit[p].kind == flitHead)
        begin
          randBits(3, r);  // short leases so they run out
          inFlit[p].length = lengthWidth'(r[2:0]);
        end
        else
        begin
          randBits(lengthWidth, r);
          inFlit[p].length = r[lengthWidth-1:0];
        end
        randBits(16, r);
        inFlit[p].data = r[15:0];
      end
    end
    @(negedge clk);
    req = '0;
    inFlit = '0;
    waitForGrant(grantIdle, 8);
    repeat (3) @(negedge clk);
    $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount, timeouts);
    if (errorCount == 0 && timeouts == 0 && checkCount > 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
logic/nocPkg.sv
logic/leaseTimer.sv
logic/grantFsm.sv
logic/flitSelect.sv
logic/portArbiter.sv
verif/clockGen.sv
verif/arbiterChecker.sv
verif/tbPortArbiter.sv
